//--- Bender.yml
package:
  name: panel_cmd

sources:
  - files:
      - rtl/panel_pkg.sv
      - rtl/field_capture.sv
      - rtl/cmd_fill_rect.sv
      - rtl/fill_area.sv
      - rtl/frame_buffer.sv
      - rtl/cmd_dispatch.sv
      - rtl/panel_cmd_top.sv
  - target: simulation
    files:
      - dv/panel_cmd_sva.sv
      - dv/panel_cmd_tb.sv

//--- dv/panel_cmd_sva.sv
`timescale 1ns/1ps
module panel_cmd_sva
    import panel_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic ready,
    input logic done,
    input logic out_valid,
    input logic wr_en,
    input row_t wr_row,
    input col_t wr_col
);
    done_pulse_a: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held for more than one cycle.");

    // answer bytes only while the host is held off.
    out_not_ready_a: assert property (@(posedge clk) disable iff (reset) !(out_valid && ready))
        else $error("out_valid high while ready is high.");

    wr_inside_a: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_col < NUM_COLS) && (wr_row < NUM_ROWS))
        else $error("pixel write outside the panel.");

endmodule

bind panel_cmd_top panel_cmd_sva sva_i (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .done      (done),
    .out_valid (out_valid),
    .wr_en     (wr_en),
    .wr_row    (wr_row),
    .wr_col    (wr_col)
);

//--- dv/panel_cmd_tb.sv
`timescale 1ns/1ps
module panel_cmd_tb;
    import panel_pkg::*;

    localparam int WAIT_LIMIT = 20000;    // covers a full panel fill.

    logic       clk;
    logic       reset;
    logic [7:0] byte_in;
    logic       byte_valid;
    logic       ready;
    logic       done;
    logic [7:0] out_byte;
    logic       out_valid;
    logic       cmd_error;

    pixel_t      model [NUM_ROWS][NUM_COLS];    // expected panel content.
    logic [31:0] rng;

    panel_cmd_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ******************************
    // helpers.
    // ******************************
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("ERROR %s: expected %0h, actual %0h", test, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // hold the strobe until a cycle with ready high.
    task automatic send_byte(input logic [7:0] b);
        int   n;
        logic taken;
        n = 0;
        @(posedge clk);
        byte_in    <= b;
        byte_valid <= 1'b1;
        do begin
            @(negedge clk);
            taken = ready;
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) stop_run("timeout while waiting for ready to take a byte");
        end while (!taken);
        byte_valid <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) stop_run("timeout while waiting for done");
        end while (!done);
    endtask

    task automatic fill_rect(input int x, input int y, input int w, input int h,
                             input pixel_t color, input int junk);
        int xc;
        int yc;
        int wc;
        int hc;
        xc = x & 'h1ff;    // operands as the captures hold them.
        yc = y & 'h1f;
        wc = w & 'h1ff;
        hc = h & 'h1f;
        send_byte(OP_FILL_RECT);
        send_byte(x[15:8]);
        send_byte(x[7:0]);
        send_byte(y[7:0]);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
        send_byte(h[7:0]);
        send_byte(color[15:8]);
        send_byte(color[7:0]);
        // strobes while the walker runs.
        for (int i = 0; i < junk; i++) begin
            byte_in    <= 8'(OP_READ_PIXEL + i);
            byte_valid <= 1'b1;
            @(negedge clk);
            check_value("ready_gating", 0, ready);
            @(posedge clk);
        end
        byte_valid <= 1'b0;
        wait_done();
        for (int r = yc; r < yc + hc && r < NUM_ROWS; r++) begin
            for (int c = xc; c < xc + wc && c < NUM_COLS; c++) begin
                model[r][c] = color;
            end
        end
    endtask

    task automatic read_pixel(input int x, input int y, output pixel_t value);
        int n;
        send_byte(OP_READ_PIXEL);
        send_byte(x[15:8]);
        send_byte(x[7:0]);
        send_byte(y[7:0]);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) stop_run("timeout while waiting for the pixel answer");
        end while (!out_valid);
        value[15:8] = out_byte;
        @(negedge clk);
        if (!out_valid) stop_run("the second answer byte never came");
        value[7:0] = out_byte;
    endtask

    task automatic check_pixel(input string test, input int x, input int y);
        pixel_t value;
        read_pixel(x, y, value);
        check_value(test, model[y][x], value);
    endtask

    // ******************************
    // tests.
    // ******************************
    task automatic test_reset();
        @(negedge clk);
        check_value("reset", 1, ready);
        check_value("reset", 0, done);
        check_value("reset", 0, out_valid);
        check_value("reset", 0, cmd_error);
    endtask

    task automatic test_fill_readback();
        fill_rect(40, 8, 6, 4, 16'hbeef, 0);
        for (int r = 7; r <= 12; r++) begin
            for (int c = 39; c <= 46; c++) begin
                check_pixel("fill_readback", c, r);    // inside and border.
            end
        end
    endtask

    task automatic test_clipping();
        fill_rect(300, 28, 40, 10, 16'h0f0f, 0);
        check_pixel("clipping", 319, 31);
        check_pixel("clipping", 300, 28);
        check_pixel("clipping", 299, 27);
        for (int r = 28; r < NUM_ROWS; r++) begin
            check_pixel("clipping", 0, r);    // no wrap into column 0.
        end
        for (int c = 300; c < NUM_COLS; c += 4) begin
            check_pixel("clipping", c, 0);
        end
        fill_rect(10, 5, 0, 4, 16'hdead, 0);
        check_pixel("zero_width", 10, 5);
        check_pixel("zero_width", 10, 6);
    endtask

    task automatic test_random();
        int x;
        int y;
        int w;
        int h;
        for (int i = 0; i < 20; i++) begin
            rng = xorshift(rng);
            x = rng % NUM_COLS;
            rng = xorshift(rng);
            y = rng % NUM_ROWS;
            rng = xorshift(rng);
            w = rng % 64;
            rng = xorshift(rng);
            h = rng % 12;
            rng = xorshift(rng);
            fill_rect(x, y, w, h, rng[15:0], 0);
        end
        for (int i = 0; i < 40; i++) begin
            rng = xorshift(rng);
            x = rng % NUM_COLS;
            rng = xorshift(rng);
            y = rng % NUM_ROWS;
            check_pixel("random", x, y);
        end
    endtask

    task automatic test_bad_opcode();
        int pulses;
        send_byte(8'h7f);
        pulses = 0;
        repeat (4) begin
            @(negedge clk);
            if (cmd_error) pulses++;
        end
        check_value("bad_opcode", 1, pulses);
        check_pixel("bad_opcode", 45, 10);
    endtask

    task automatic test_ready_gating();
        fill_rect(100, 3, 5, 3, 16'h5a5a, 3);
        for (int r = 2; r <= 6; r++) begin
            for (int c = 99; c <= 105; c++) begin
                check_pixel("ready_gating", c, r);
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        byte_in    = '0;
        byte_valid = 1'b0;
        rng        = 32'hd64308ec;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        // frame buffer powers up unknown.
        fill_rect(0, 0, NUM_COLS, NUM_ROWS - 1, 16'h1234, 0);
        fill_rect(0, NUM_ROWS - 1, NUM_COLS, 1, 16'h1234, 0);    // height byte stops at 31.
        test_fill_readback();
        test_clipping();
        test_random();
        test_bad_opcode();
        test_ready_gating();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- rtl/cmd_dispatch.sv
`timescale 1ns/1ps
module cmd_dispatch
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    input  logic       fill_busy,
    output logic       fill_byte_valid,
    output logic       rd_en,
    output row_t       rd_row,
    output col_t       rd_col,
    input  pixel_t     rd_data,
    output logic       ready,
    output logic [7:0] out_byte,
    output logic       out_valid,
    output logic       cmd_error
);
    typedef enum logic [2:0] {
        S_OP,
        S_ARGS,
        S_RD_REQ,
        S_OUT_HI,
        S_OUT_LO
    } state_t;

    typedef logic [$clog2(FILL_RECT_OPERANDS)-1:0] cnt_t;

    state_t state;
    op_t    op;
    cnt_t   arg_cnt;
    logic   take;
    logic   last_arg;

    assign ready    = ((state == S_OP) || (state == S_ARGS)) && !fill_busy;
    assign take     = byte_valid && ready;
    assign last_arg = (op == OP_FILL_RECT) ? (arg_cnt == cnt_t'(FILL_RECT_OPERANDS - 1))
                                           : (arg_cnt == cnt_t'(READ_PIXEL_OPERANDS - 1));

    assign fill_byte_valid = take && (state == S_ARGS) && (op == OP_FILL_RECT);

    // ******************************
    // opcode and operand tracking.
    // ******************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_OP;
            op        <= '0;
            arg_cnt   <= '0;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                S_OP: begin
                    if (take) begin
                        op      <= byte_in;
                        arg_cnt <= '0;
                        if (byte_in == OP_FILL_RECT || byte_in == OP_READ_PIXEL) begin
                            state <= S_ARGS;
                        end else begin
                            cmd_error <= 1'b1;    // dropped, next byte is an opcode.
                        end
                    end
                end
                S_ARGS: begin
                    if (take) begin
                        arg_cnt <= arg_cnt + 1'b1;
                        if (last_arg) begin
                            state <= (op == OP_READ_PIXEL) ? S_RD_REQ : S_OP;
                        end
                    end
                end
                S_RD_REQ: state <= S_OUT_HI;
                S_OUT_HI: state <= S_OUT_LO;
                default:  state <= S_OP;
            endcase
        end
    end

    // read address, x msb first then y.
    always_ff @(posedge clk) begin
        if (take && state == S_ARGS && op == OP_READ_PIXEL) begin
            if (arg_cnt < cnt_t'(COL_BYTES)) begin
                rd_col <= col_t'({rd_col, byte_in});
            end else begin
                rd_row <= row_t'(byte_in);
            end
        end
    end

    // ******************************
    // answer.
    // ******************************
    assign rd_en     = (state == S_RD_REQ);
    assign out_valid = (state == S_OUT_HI) || (state == S_OUT_LO);
    assign out_byte  = (state == S_OUT_HI) ? rd_data[15:8] : rd_data[7:0];

endmodule

//--- rtl/cmd_fill_rect.sv
`timescale 1ns/1ps
module cmd_fill_rect
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fill_byte_valid,
    input  logic [7:0] byte_in,
    output logic       start,
    output col_t       x1,
    output row_t       y1,
    output col_t       width,
    output row_t       height,
    output pixel_t     color,
    input  logic       area_done,
    output logic       busy,
    output logic       done
);
    typedef enum logic [2:0] {
        S_X1,
        S_Y1,
        S_WIDTH,
        S_HEIGHT,
        S_COLOR,
        S_START,
        S_RUNNING,
        S_DONE
    } state_t;

    state_t state;
    logic   x1_last;
    logic   width_last;
    logic   color_last;

    // ******************************
    // operand captures.
    // ******************************
    field_capture #(.field_t(col_t)) x1_cap_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (done),
        .load    (fill_byte_valid && state == S_X1),
        .byte_in (byte_in),
        .value   (x1),
        .last    (x1_last)
    );

    field_capture #(.field_t(col_t)) width_cap_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (done),
        .load    (fill_byte_valid && state == S_WIDTH),
        .byte_in (byte_in),
        .value   (width),
        .last    (width_last)
    );

    field_capture #(.field_t(pixel_t)) color_cap_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (done),
        .load    (fill_byte_valid && state == S_COLOR),
        .byte_in (byte_in),
        .value   (color),
        .last    (color_last)
    );

    // single byte fields, low bits only.
    always_ff @(posedge clk) begin
        if (fill_byte_valid && state == S_Y1) begin
            y1 <= row_t'(byte_in);
        end
        if (fill_byte_valid && state == S_HEIGHT) begin
            height <= row_t'(byte_in);
        end
    end

    // ******************************
    // sequencing.
    // ******************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_X1;
        end else begin
            case (state)
                S_X1:      if (fill_byte_valid && x1_last) state <= S_Y1;
                S_Y1:      if (fill_byte_valid) state <= S_WIDTH;
                S_WIDTH:   if (fill_byte_valid && width_last) state <= S_HEIGHT;
                S_HEIGHT:  if (fill_byte_valid) state <= S_COLOR;
                S_COLOR:   if (fill_byte_valid && color_last) state <= S_START;
                S_START:   state <= S_RUNNING;
                S_RUNNING: if (area_done) state <= S_DONE;
                default:   state <= S_X1;    // S_DONE.
            endcase
        end
    end

    assign start = (state == S_START);
    assign busy  = (state == S_START) || (state == S_RUNNING);
    assign done  = (state == S_DONE);

endmodule

//--- rtl/field_capture.sv
`timescale 1ns/1ps
module field_capture
    import panel_pkg::*;
#(
    parameter type field_t = pixel_t
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear,
    input  logic       load,
    input  logic [7:0] byte_in,
    output field_t     value,
    output logic       last
);
    localparam int NUM_BYTES = ($bits(field_t) + 7) / 8;
    localparam int CNT_W = (NUM_BYTES > 1) ? $clog2(NUM_BYTES) : 1;

    logic [CNT_W-1:0] count;

    assign last = (count == CNT_W'(NUM_BYTES - 1));    // next load ends the field.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (load) begin
            count <= last ? '0 : count + 1'b1;
        end
    end

    // msb first, each new byte pushes the older ones up.
    always_ff @(posedge clk) begin
        if (load) begin
            value <= field_t'({value, byte_in});
        end
    end

endmodule

//--- rtl/fill_area.sv
`timescale 1ns/1ps
module fill_area
    import panel_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  col_t   x1,
    input  row_t   y1,
    input  col_t   width,
    input  row_t   height,
    input  pixel_t color,
    output logic   wr_en,
    output row_t   wr_row,
    output col_t   wr_col,
    output pixel_t wr_data,
    output logic   area_done
);
    // one spare bit so the end bound can reach past the panel.
    typedef logic [$bits(col_t):0] col_ext_t;
    typedef logic [$bits(row_t):0] row_ext_t;

    col_ext_t col_sum, col_lim, col_end;
    row_ext_t row_sum, row_lim, row_end;
    col_t     col_first;
    logic     nonempty;
    logic     active;
    logic     last_col;
    logic     last_row;

    // ******************************
    // clipping.
    // ******************************
    assign col_sum  = col_ext_t'(x1) + col_ext_t'(width);
    assign row_sum  = row_ext_t'(y1) + row_ext_t'(height);
    assign col_lim  = (col_sum > col_ext_t'(NUM_COLS)) ? col_ext_t'(NUM_COLS) : col_sum;
    assign row_lim  = (row_sum > row_ext_t'(NUM_ROWS)) ? row_ext_t'(NUM_ROWS) : row_sum;
    assign nonempty = (col_lim > col_ext_t'(x1)) && (row_lim > row_ext_t'(y1));

    assign last_col = (col_ext_t'(wr_col) + 1'b1 == col_end);
    assign last_row = (row_ext_t'(wr_row) + 1'b1 == row_end);
    assign wr_en    = active;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            area_done <= 1'b0;
        end else begin
            area_done <= 1'b0;
            if (start) begin
                active    <= nonempty;
                area_done <= !nonempty;    // nothing to paint.
            end else if (active && last_col && last_row) begin
                active    <= 1'b0;
                area_done <= 1'b1;
            end
        end
    end

    // row-major walk.
    always_ff @(posedge clk) begin
        if (start) begin
            wr_col    <= x1;
            wr_row    <= y1;
            col_first <= x1;
            col_end   <= col_lim;
            row_end   <= row_lim;
            wr_data   <= color;
        end else if (active) begin
            if (last_col) begin
                wr_col <= col_first;
                wr_row <= wr_row + 1'b1;
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

endmodule

//--- rtl/frame_buffer.sv
`timescale 1ns/1ps
module frame_buffer
    import panel_pkg::*;
(
    input  logic   clk,
    input  logic   wr_en,
    input  row_t   wr_row,
    input  col_t   wr_col,
    input  pixel_t wr_data,
    input  logic   rd_en,
    input  row_t   rd_row,
    input  col_t   rd_col,
    output pixel_t rd_data
);
    pixel_t mem [NUM_ROWS][NUM_COLS];

    // write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row][wr_col] <= wr_data;
        end
    end

    // registered read, holds until the next rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_row][rd_col];
        end
    end

endmodule

//--- rtl/panel_cmd_top.sv
`timescale 1ns/1ps
module panel_cmd_top
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    output logic       ready,
    output logic       done,
    output logic [7:0] out_byte,
    output logic       out_valid,
    output logic       cmd_error
);
    logic   fill_byte_valid;
    logic   fill_busy;
    logic   start;
    logic   area_done;
    col_t   x1;
    row_t   y1;
    col_t   width;
    row_t   height;
    pixel_t color;
    logic   wr_en;
    row_t   wr_row;
    col_t   wr_col;
    pixel_t wr_data;
    logic   rd_en;
    row_t   rd_row;
    col_t   rd_col;
    pixel_t rd_data;

    cmd_dispatch dispatch_i (
        .clk             (clk),
        .reset           (reset),
        .byte_in         (byte_in),
        .byte_valid      (byte_valid),
        .fill_busy       (fill_busy),
        .fill_byte_valid (fill_byte_valid),
        .rd_en           (rd_en),
        .rd_row          (rd_row),
        .rd_col          (rd_col),
        .rd_data         (rd_data),
        .ready           (ready),
        .out_byte        (out_byte),
        .out_valid       (out_valid),
        .cmd_error       (cmd_error)
    );

    cmd_fill_rect fill_rect_i (
        .clk             (clk),
        .reset           (reset),
        .fill_byte_valid (fill_byte_valid),
        .byte_in         (byte_in),
        .start           (start),
        .x1              (x1),
        .y1              (y1),
        .width           (width),
        .height          (height),
        .color           (color),
        .area_done       (area_done),
        .busy            (fill_busy),
        .done            (done)
    );

    fill_area fill_area_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .x1        (x1),
        .y1        (y1),
        .width     (width),
        .height    (height),
        .color     (color),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_data   (wr_data),
        .area_done (area_done)
    );

    frame_buffer frame_buffer_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_data (rd_data)
    );

endmodule

//--- rtl/panel_pkg.sv
package panel_pkg;

    // ******************************
    // panel geometry.
    // ******************************
    localparam int NUM_COLS = 320;
    localparam int NUM_ROWS = 32;

    localparam int BYTES_PER_PIXEL = 2;
    localparam int COL_BYTES = 2;    // x and width operands.

    // operand bytes after each opcode.
    localparam int FILL_RECT_OPERANDS = 2 * COL_BYTES + 2 + BYTES_PER_PIXEL;
    localparam int READ_PIXEL_OPERANDS = COL_BYTES + 1;

    // ******************************
    // types.
    // ******************************
    typedef logic [8:0] col_t;
    typedef logic [4:0] row_t;
    typedef logic [15:0] pixel_t;
    typedef logic [7:0] op_t;

    localparam op_t OP_FILL_RECT = 8'h01;
    localparam op_t OP_READ_PIXEL = 8'h02;

endpackage

//--- src.f
rtl/panel_pkg.sv
rtl/field_capture.sv
rtl/cmd_fill_rect.sv
rtl/fill_area.sv
rtl/frame_buffer.sv
rtl/cmd_dispatch.sv
rtl/panel_cmd_top.sv
dv/panel_cmd_sva.sv
dv/panel_cmd_tb.sv
